// ==== all.f ====
hdl/ro_pkg.sv
hdl/ro_id_pool.sv
hdl/ro_task_dispatch.sv
hdl/ro_burst_splitter.sv
hdl/ro_resp_unpacker.sv
hdl/ro_stage.sv
bench/ro_mem_model.sv
bench/ro_stage_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert -f all.f --top-module ro_stage_tb -Mdir obj_dir
	obj_dir/Vro_stage_tb | tee $(LOG)
	grep -q "Testbench passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== bench/ro_stage_tb.sv ====
`timescale 1ns/1ps

module ro_stage_tb;
   import ro_pkg::*;

   localparam logic [31:0] OFFSET_BASE = 32'h1000;
   localparam logic [31:0] NEIGHBOR_BASE = 32'h2004;   // puts some edges across a line
   localparam int N_VERTS = 20;
   localparam int N_TASKS = 90;

   typedef struct packed {
      task_t       tsk;
      subtype_t    sub;
      cq_slot_t    slot;
      logic [63:0] data;
      logic        last;
   } out_item_t;

   typedef struct packed {
      task_t    tsk;
      cq_slot_t slot;
   } child_item_t;

   logic        clk = 1'b0;
   logic        rstn;
   logic        in_valid;
   logic        in_ready;
   subtype_t    in_subtype;
   task_t       in_task;
   logic [63:0] in_data;
   cq_slot_t    in_slot;
   logic        arvalid;
   logic        arready;
   logic [31:0] araddr;
   arid_t       arid;
   logic        rvalid;
   logic        rready;
   arid_t       rid;
   line_t       rdata;
   logic        out_valid;
   logic        out_ready;
   task_t       out_task;
   subtype_t    out_subtype;
   cq_slot_t    out_slot;
   logic [63:0] out_data;
   logic        out_last;
   logic        child_valid;
   logic        child_ready;
   task_t       child_task;
   cq_slot_t    child_slot;
   logic        idle;
   logic        drained;

   out_item_t   out_q [$];
   child_item_t child_q [$];
   logic [31:0] ar_q [$];
   out_item_t   exp_out = '0;
   child_item_t exp_child = '0;
   logic [31:0] exp_araddr = '0;
   logic        exp_out_have = 1'b0;
   logic        exp_child_have = 1'b0;
   logic        exp_ar_have = 1'b0;
   logic [N_ARIDS-1:0] id_out = '0;   // read ids with a beat in flight
   int          errors = 0;
   int          n_out = 0;
   int          n_child = 0;
   int          n_ar = 0;

   always #4 clk = ~clk;

   ro_stage dut (
      .clk (clk), .rstn (rstn),
      .offset_base (OFFSET_BASE), .neighbor_base (NEIGHBOR_BASE),
      .in_valid (in_valid), .in_ready (in_ready), .in_subtype (in_subtype),
      .in_task (in_task), .in_data (in_data), .in_slot (in_slot),
      .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
      .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata),
      .out_valid (out_valid), .out_ready (out_ready), .out_task (out_task),
      .out_subtype (out_subtype), .out_slot (out_slot), .out_data (out_data),
      .out_last (out_last),
      .child_valid (child_valid), .child_ready (child_ready),
      .child_task (child_task), .child_slot (child_slot),
      .idle (idle)
   );

   ro_mem_model #(
      .OFFSET_BASE (OFFSET_BASE), .NEIGHBOR_BASE (NEIGHBOR_BASE), .N_VERTS (N_VERTS)
   ) u_mem (
      .clk (clk), .rstn (rstn),
      .arvalid (arvalid), .arready (arready), .araddr (araddr), .arid (arid),
      .rvalid (rvalid), .rready (rready), .rid (rid), .rdata (rdata)
   );

   function automatic logic [31:0] edge_start(input int v);
      int sum;
      sum = 0;
      for (int u = 0; u < v; u++) sum += u % 5;
      return 32'(sum);
   endfunction

   // one address per line touched by the read
   task automatic expect_beats(input logic [31:0] addr, input int words);
      logic [31:0] a;
      int left;
      a = addr;
      left = words;
      while (left > 0) begin
         ar_q.push_back(a);
         left -= 16 - int'(a[5:2]);
         a = {a[31:6] + 26'd1, 6'd0};
      end
   endtask

   always @(posedge clk) begin
      if (rstn) begin
         if (out_valid && out_ready && out_q.size() > 0) begin
            void'(out_q.pop_front());
            n_out++;
         end
         if (child_valid && child_ready && child_q.size() > 0) begin
            void'(child_q.pop_front());
            n_child++;
         end
         if (arvalid && arready && ar_q.size() > 0) begin
            void'(ar_q.pop_front());
            n_ar++;
         end
      end
      exp_out_have <= out_q.size() > 0;
      exp_child_have <= child_q.size() > 0;
      exp_ar_have <= ar_q.size() > 0;
      if (out_q.size() > 0) exp_out <= out_q[0];
      if (child_q.size() > 0) exp_child <= child_q[0];
      if (ar_q.size() > 0) exp_araddr <= ar_q[0];
   end

   always @(posedge clk) begin
      if (!rstn) begin
         id_out <= '0;
      end else begin
         if (rvalid && rready) id_out[rid] <= 1'b0;
         if (arvalid && arready) id_out[arid] <= 1'b1;
      end
   end

   a_reset_state: assert property (@(posedge clk)
      $rose(rstn) |-> idle && rready && in_ready && !arvalid && !out_valid && !child_valid)
      else begin
         errors++;
         $display("error %0t: outputs not in their reset state", $time);
      end

   a_empty_list: assert property (@(posedge clk) disable iff (!rstn)
      in_valid && in_subtype == SUB_EDGES && in_data[63:32] == in_data[31:0] |-> in_ready)
      else begin
         errors++;
         $display("error %0t: empty edge list not taken at once", $time);
      end

   a_out_item: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && out_ready |->
         exp_out_have && {out_task, out_subtype, out_slot, out_data, out_last} == exp_out)
      else begin
         errors++;
         $display("error %0t: output data %h last %b, expected %h last %b", $time,
                  $sampled(out_data), $sampled(out_last),
                  $sampled(exp_out.data), $sampled(exp_out.last));
      end

   a_child_item: assert property (@(posedge clk) disable iff (!rstn)
      child_valid && child_ready |-> exp_child_have && {child_task, child_slot} == exp_child)
      else begin
         errors++;
         $display("error %0t: child %h, expected %h", $time,
                  $sampled(child_task), $sampled(exp_child.tsk));
      end

   a_read_addr: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && arready |-> exp_ar_have && araddr == exp_araddr)
      else begin
         errors++;
         $display("error %0t: read address %h, expected %h", $time,
                  $sampled(araddr), $sampled(exp_araddr));
      end

   a_read_id: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && arready |-> !id_out[arid])
      else begin
         errors++;
         $display("error %0t: read id %0d reused while still in flight", $time,
                  $sampled(arid));
      end

   a_drained: assert property (@(posedge clk)
      drained |-> idle && !arvalid && !out_valid && !child_valid && id_out == '0)
      else begin
         errors++;
         $display("error %0t: stage not idle after draining", $time);
      end

   // random back-pressure on both outputs
   initial begin
      out_ready = 1'b0;
      child_ready = 1'b0;
      forever begin
         @(posedge clk);
         #1;
         out_ready = ($urandom % 4) != 0;
         child_ready = ($urandom % 3) != 0;
      end
   end

   initial begin
      repeat (N_TASKS * 200) @(posedge clk);
      $display("timeout: tasks not drained after %0d cycles", N_TASKS * 200);
      $display("Testbench failed");
      $finish;
   end

   initial begin
      int kind;
      int v;
      int e;
      int n_edges;
      logic [31:0] start;
      logic [31:0] stop;
      out_item_t item;
      child_item_t ch;
      void'($urandom(32'hd14e_de4f));
      rstn = 1'b0;
      in_valid = 1'b0;
      in_subtype = SUB_OFFSETS;
      in_task = '0;
      in_data = '0;
      in_slot = '0;
      drained = 1'b0;
      n_edges = int'(edge_start(N_VERTS));
      repeat (5) @(posedge clk);
      #1 rstn = 1'b1;
      repeat (2) @(posedge clk);
      for (int i = 0; i < N_TASKS; i++) begin
         kind = (i < 3) ? i : int'($urandom % 3);
         v = (i == 1) ? 5 : int'($urandom % N_VERTS);   // vertex 5 has no edges
         e = int'($urandom % n_edges);
         start = edge_start(v);
         stop = edge_start(v + 1);
         #1;
         in_valid = 1'b1;
         in_subtype = subtype_t'(kind);
         in_task.ts = $urandom;
         in_task.locale = (kind == 0) ? 32'(v) : $urandom;
         in_slot = cq_slot_t'($urandom);
         item.tsk = in_task;
         item.slot = in_slot;
         case (kind)
            0: begin
               in_data = {$urandom, $urandom};
               item.sub = SUB_EDGES;
               item.data = {stop, start};
               item.last = 1'b0;
               out_q.push_back(item);
               expect_beats(OFFSET_BASE + 32'(4 * v), 2);
            end
            1: begin
               in_data = {stop, start};
               item.sub = SUB_CHILD;
               for (int k = int'(start); k < int'(stop); k++) begin
                  item.data = {32'(k + 10), 32'(3 * k + 1)};
                  item.last = k == int'(stop) - 1;
                  out_q.push_back(item);
               end
               if (stop != start) begin
                  expect_beats(NEIGHBOR_BASE + 32'(8 * int'(start)), 2 * int'(stop - start));
               end
            end
            default: begin
               in_data = {32'(e + 10), 32'(3 * e + 1)};
               ch.tsk.locale = 32'(3 * e + 1);
               ch.tsk.ts = in_task.ts + 32'(e + 10);
               ch.slot = in_slot;
               child_q.push_back(ch);
            end
         endcase
         @(posedge clk);
         while (!in_ready) @(posedge clk);
      end
      #1 in_valid = 1'b0;
      do begin
         @(posedge clk);
         #1;
      end while (out_q.size() > 0 || child_q.size() > 0 || ar_q.size() > 0 || !idle);
      repeat (2) @(posedge clk);
      #1 drained = 1'b1;
      repeat (3) @(posedge clk);
      #1 drained = 1'b0;
      $display("checked %0d outputs, %0d children, %0d read beats, %0d errors",
               n_out, n_child, n_ar, errors);
      if (errors == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

endmodule

// ==== bench/ro_mem_model.sv ====
`timescale 1ns/1ps

module ro_mem_model #(
   parameter logic [31:0] OFFSET_BASE = 32'h1000,
   parameter logic [31:0] NEIGHBOR_BASE = 32'h2004,
   parameter int N_VERTS = 20
) (
   input  logic          clk,
   input  logic          rstn,
   input  logic          arvalid,
   output logic          arready,
   input  logic [31:0]   araddr,
   input  ro_pkg::arid_t arid,
   output logic          rvalid,
   input  logic          rready,
   output ro_pkg::arid_t rid,
   output ro_pkg::line_t rdata
);
   import ro_pkg::*;

   arid_t       id_q [$];
   logic [31:0] addr_q [$];
   int          due_q [$];
   int          cycle = 0;
   int          last_due = 0;

   // offsets array, then edge array, then a filler that depends on the whole address
   function automatic logic [31:0] word_at(input logic [31:0] addr);
      int idx;
      int sum;
      int n_edges;
      n_edges = 0;
      for (int u = 0; u < N_VERTS; u++) n_edges += u % 5;
      if (addr >= OFFSET_BASE && addr < OFFSET_BASE + 32'(4 * (N_VERTS + 1))) begin
         idx = int'((addr - OFFSET_BASE) >> 2);
         sum = 0;
         for (int u = 0; u < idx; u++) sum += u % 5;   // degree of u is u mod 5
         return 32'(sum);
      end
      if (addr >= NEIGHBOR_BASE && addr < NEIGHBOR_BASE + 32'(8 * n_edges)) begin
         idx = int'((addr - NEIGHBOR_BASE) >> 2);
         if (idx % 2 == 1) return 32'(idx / 2 + 10);  // weight
         return 32'(3 * (idx / 2) + 1);                // neighbor
      end
      return addr ^ {addr[15:0], addr[31:16]} ^ 32'h9e37_79b9;
   endfunction

   function automatic line_t line_at(input logic [31:0] addr);
      line_t l;
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
         l[i*32 +: 32] = word_at({addr[31:6], 6'd0} + 32'(4 * i));
      end
      return l;
   endfunction

   // in-order responses, each beat due a random 1 to 6 cycles after its address
   initial begin
      int lat;
      arready = 1'b0;
      rvalid = 1'b0;
      rid = '0;
      rdata = '0;
      forever begin
         @(posedge clk);
         if (!rstn) begin
            id_q.delete();
            addr_q.delete();
            due_q.delete();
         end else begin
            cycle++;
            if (rvalid && rready) begin
               void'(id_q.pop_front());
               void'(addr_q.pop_front());
               void'(due_q.pop_front());
            end
            if (arvalid && arready) begin
               lat = 1 + int'($urandom % 6);
               if (cycle + lat > last_due) last_due = cycle + lat;
               id_q.push_back(arid);
               addr_q.push_back(araddr);
               due_q.push_back(last_due);
            end
         end
         #1;
         arready = rstn && ($urandom % 4 != 0);
         if (due_q.size() > 0 && due_q[0] <= cycle) begin
            rvalid = 1'b1;
            rid = id_q[0];
            rdata = line_at(addr_q[0]);
         end else begin
            rvalid = 1'b0;
         end
      end
   end

endmodule

// ==== hdl/ro_stage.sv ====
`timescale 1ns/1ps

module ro_stage (
   input  logic              clk,
   input  logic              rstn,
   input  logic [31:0]       offset_base,
   input  logic [31:0]       neighbor_base,
   input  logic              in_valid,
   output logic              in_ready,
   input  ro_pkg::subtype_t  in_subtype,
   input  ro_pkg::task_t     in_task,
   input  logic [63:0]       in_data,
   input  ro_pkg::cq_slot_t  in_slot,
   output logic              arvalid,
   input  logic              arready,
   output logic [31:0]       araddr,
   output ro_pkg::arid_t     arid,
   input  logic              rvalid,
   output logic              rready,
   input  ro_pkg::arid_t     rid,
   input  ro_pkg::line_t     rdata,
   output logic              out_valid,
   input  logic              out_ready,
   output ro_pkg::task_t     out_task,
   output ro_pkg::subtype_t  out_subtype,
   output ro_pkg::cq_slot_t  out_slot,
   output logic [63:0]       out_data,
   output logic              out_last,
   output logic              child_valid,
   input  logic              child_ready,
   output ro_pkg::task_t     child_task,
   output ro_pkg::cq_slot_t  child_slot,
   output logic              idle
);
   import ro_pkg::*;

   logic       req_valid;
   logic       req_ready;
   logic [31:0] req_addr;
   word_cnt_t  req_words;
   task_t      req_task;
   subtype_t   req_subtype;
   cq_slot_t   req_slot;
   logic       req_mark_last;

   logic       ctx_write;
   thread_t    ctx_thread;
   task_t      ctx_task;
   subtype_t   ctx_subtype;
   cq_slot_t   ctx_slot;
   logic       ctx_mark_last;
   word_cnt_t  ctx_words;
   logic       beat_mask_write;
   arid_t      beat_id;
   word_mask_t beat_mask;

   logic       rid_free;
   arid_t      rid_freed;
   logic       thread_free;
   thread_t    thread_freed;

   ro_task_dispatch u_dispatch (
      .clk           (clk),
      .rstn          (rstn),
      .offset_base   (offset_base),
      .neighbor_base (neighbor_base),
      .in_valid      (in_valid),
      .in_ready      (in_ready),
      .in_subtype    (in_subtype),
      .in_task       (in_task),
      .in_data       (in_data),
      .in_slot       (in_slot),
      .req_valid     (req_valid),
      .req_ready     (req_ready),
      .req_addr      (req_addr),
      .req_words     (req_words),
      .req_task      (req_task),
      .req_subtype   (req_subtype),
      .req_slot      (req_slot),
      .req_mark_last (req_mark_last),
      .child_valid   (child_valid),
      .child_ready   (child_ready),
      .child_task    (child_task),
      .child_slot    (child_slot)
   );

   ro_burst_splitter u_splitter (
      .clk             (clk),
      .rstn            (rstn),
      .req_valid       (req_valid),
      .req_ready       (req_ready),
      .req_addr        (req_addr),
      .req_words       (req_words),
      .req_task        (req_task),
      .req_subtype     (req_subtype),
      .req_slot        (req_slot),
      .req_mark_last   (req_mark_last),
      .arvalid         (arvalid),
      .arready         (arready),
      .araddr          (araddr),
      .arid            (arid),
      .ctx_write       (ctx_write),
      .ctx_thread      (ctx_thread),
      .ctx_task        (ctx_task),
      .ctx_subtype     (ctx_subtype),
      .ctx_slot        (ctx_slot),
      .ctx_mark_last   (ctx_mark_last),
      .ctx_words       (ctx_words),
      .beat_mask_write (beat_mask_write),
      .beat_id         (beat_id),
      .beat_mask       (beat_mask),
      .rid_free        (rid_free),
      .rid_freed       (rid_freed),
      .thread_free     (thread_free),
      .thread_freed    (thread_freed),
      .idle            (idle)
   );

   ro_resp_unpacker u_unpacker (
      .clk             (clk),
      .rstn            (rstn),
      .ctx_write       (ctx_write),
      .ctx_thread      (ctx_thread),
      .ctx_task        (ctx_task),
      .ctx_subtype     (ctx_subtype),
      .ctx_slot        (ctx_slot),
      .ctx_mark_last   (ctx_mark_last),
      .ctx_words       (ctx_words),
      .beat_mask_write (beat_mask_write),
      .beat_id         (beat_id),
      .beat_mask       (beat_mask),
      .rvalid          (rvalid),
      .rready          (rready),
      .rid             (rid),
      .rdata           (rdata),
      .rid_free        (rid_free),
      .rid_freed       (rid_freed),
      .thread_free     (thread_free),
      .thread_freed    (thread_freed),
      .out_valid       (out_valid),
      .out_ready       (out_ready),
      .out_task        (out_task),
      .out_subtype     (out_subtype),
      .out_slot        (out_slot),
      .out_data        (out_data),
      .out_last        (out_last)
   );

endmodule

// ==== hdl/ro_resp_unpacker.sv ====
`timescale 1ns/1ps

module ro_resp_unpacker (
   input  logic               clk,
   input  logic               rstn,
   input  logic               ctx_write,
   input  ro_pkg::thread_t    ctx_thread,
   input  ro_pkg::task_t      ctx_task,
   input  ro_pkg::subtype_t   ctx_subtype,
   input  ro_pkg::cq_slot_t   ctx_slot,
   input  logic               ctx_mark_last,
   input  ro_pkg::word_cnt_t  ctx_words,
   input  logic               beat_mask_write,
   input  ro_pkg::arid_t      beat_id,
   input  ro_pkg::word_mask_t beat_mask,
   input  logic               rvalid,
   output logic               rready,
   input  ro_pkg::arid_t      rid,
   input  ro_pkg::line_t      rdata,
   output logic               rid_free,
   output ro_pkg::arid_t      rid_freed,
   output logic               thread_free,
   output ro_pkg::thread_t    thread_freed,
   output logic               out_valid,
   input  logic               out_ready,
   output ro_pkg::task_t      out_task,
   output ro_pkg::subtype_t   out_subtype,
   output ro_pkg::cq_slot_t   out_slot,
   output logic [63:0]        out_data,
   output logic               out_last
);
   import ro_pkg::*;

   // per-thread context
   task_t      task_m [N_THREADS];
   subtype_t   subtype_m [N_THREADS];
   cq_slot_t   slot_m [N_THREADS];
   logic       mark_m [N_THREADS];
   word_cnt_t  rem_m [N_THREADS];
   logic [31:0] held_m [N_THREADS];   // first half of a straddling item

   // per read id
   thread_t    id_thread [N_ARIDS];
   word_mask_t id_mask [N_ARIDS];

   thread_t    burst_thread;
   logic       line_valid;
   line_t      line_data;
   word_mask_t line_mask;
   thread_t    cur_thread;

   logic [3:0]  lo;
   logic [3:0]  hi;
   logic [31:0] w0;
   logic [31:0] w1;
   logic        v1;
   word_cnt_t   rem;
   word_cnt_t   used;
   word_mask_t  clear;
   logic        absorb;
   logic        step;
   logic        item_last;

   assign rready = !line_valid;
   assign rid_free = rvalid && rready;
   assign rid_freed = rid;

   always_comb begin
      lo = '0;
      for (int i = WORDS_PER_LINE - 1; i >= 0; i--) begin
         if (line_mask[i]) lo = 4'(i);   // lowest set word wins
      end
   end

   assign hi = lo + 4'd1;
   assign w0 = line_data[{lo, 5'd0} +: 32];
   assign w1 = line_data[{hi, 5'd0} +: 32];
   assign v1 = (lo != 4'(WORDS_PER_LINE - 1)) && line_mask[hi];
   assign rem = rem_m[cur_thread];

   // odd count left means the held half is waiting for this word
   always_comb begin
      clear = '0;
      clear[lo] = 1'b1;
      used = word_cnt_t'(1);
      absorb = 1'b0;
      out_data = {w0, held_m[cur_thread]};
      if (!rem[0]) begin
         if (v1) begin
            out_data = {w1, w0};
            clear[hi] = 1'b1;
            used = word_cnt_t'(ITEM_WORDS);
         end else begin
            absorb = 1'b1;
         end
      end
   end

   assign out_valid = line_valid && !absorb;
   assign step = line_valid && (absorb || out_ready);
   assign item_last = rem == used;
   assign out_last = item_last && mark_m[cur_thread];
   assign out_task = task_m[cur_thread];
   assign out_subtype = subtype_m[cur_thread];
   assign out_slot = slot_m[cur_thread];

   assign thread_free = out_valid && out_ready && item_last;
   assign thread_freed = cur_thread;

   always_ff @(posedge clk) begin
      if (!rstn) begin
         line_valid <= 1'b0;
      end else if (rvalid && rready) begin
         line_valid <= 1'b1;
      end else if (step && (line_mask & ~clear) == '0) begin
         line_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (rvalid && rready) begin
         line_data <= rdata;
         line_mask <= id_mask[rid];
         cur_thread <= id_thread[rid];
      end else if (step) begin
         line_mask <= line_mask & ~clear;
      end
   end

   always_ff @(posedge clk) begin
      if (ctx_write) begin
         task_m[ctx_thread] <= ctx_task;
         subtype_m[ctx_thread] <= ctx_subtype;
         slot_m[ctx_thread] <= ctx_slot;
         mark_m[ctx_thread] <= ctx_mark_last;
         rem_m[ctx_thread] <= ctx_words;
         burst_thread <= ctx_thread;   // beats that follow belong to this thread
      end
      if (beat_mask_write) begin
         id_thread[beat_id] <= burst_thread;
         id_mask[beat_id] <= beat_mask;
      end
      if (step) begin
         rem_m[cur_thread] <= rem - used;
         if (absorb) held_m[cur_thread] <= w0;
      end
   end

   a_out_hold: assert property (@(posedge clk) disable iff (!rstn)
      out_valid && !out_ready |=> out_valid && $stable(out_data) && $stable(out_last))
      else $error("output item changed while stalled");

endmodule

// ==== hdl/ro_burst_splitter.sv ====
`timescale 1ns/1ps

module ro_burst_splitter (
   input  logic               clk,
   input  logic               rstn,
   input  logic               req_valid,
   output logic               req_ready,
   input  logic [31:0]        req_addr,
   input  ro_pkg::word_cnt_t  req_words,
   input  ro_pkg::task_t      req_task,
   input  ro_pkg::subtype_t   req_subtype,
   input  ro_pkg::cq_slot_t   req_slot,
   input  logic               req_mark_last,
   output logic               arvalid,
   input  logic               arready,
   output logic [31:0]        araddr,
   output ro_pkg::arid_t      arid,
   output logic               ctx_write,
   output ro_pkg::thread_t    ctx_thread,
   output ro_pkg::task_t      ctx_task,
   output ro_pkg::subtype_t   ctx_subtype,
   output ro_pkg::cq_slot_t   ctx_slot,
   output logic               ctx_mark_last,
   output ro_pkg::word_cnt_t  ctx_words,
   output logic               beat_mask_write,
   output ro_pkg::arid_t      beat_id,
   output ro_pkg::word_mask_t beat_mask,
   input  logic               rid_free,
   input  ro_pkg::arid_t      rid_freed,
   input  logic               thread_free,
   input  ro_pkg::thread_t    thread_freed,
   output logic               idle
);
   import ro_pkg::*;

   logic        busy;
   logic [31:0] cur_addr;
   word_cnt_t   words_left;
   logic [4:0]  room;          // words from cur_addr to the end of its line
   word_cnt_t   beat_words;
   logic        last_beat;
   logic        thread_empty;
   logic        arid_empty;
   logic        arid_all_free;
   logic        ar_fire;

   ro_id_pool #(.LOG_DEPTH(LOG_N_THREADS)) u_thread_pool (
      .clk     (clk),
      .rstn    (rstn),
      .push    (thread_free),
      .push_id (thread_freed),
      .pop     (ctx_write),
      .top_id  (ctx_thread),
      .empty   (thread_empty),
      .full    (idle)
   );

   ro_id_pool #(.LOG_DEPTH(LOG_N_ARIDS)) u_arid_pool (
      .clk     (clk),
      .rstn    (rstn),
      .push    (rid_free),
      .push_id (rid_freed),
      .pop     (ar_fire),
      .top_id  (arid),
      .empty   (arid_empty),
      .full    (arid_all_free)
   );

   assign req_ready = !thread_empty && !busy;
   assign ctx_write = req_valid && req_ready;
   assign ctx_task = req_task;
   assign ctx_subtype = req_subtype;
   assign ctx_slot = req_slot;
   assign ctx_mark_last = req_mark_last;
   assign ctx_words = req_words;

   assign arvalid = busy && !arid_empty;
   assign araddr = cur_addr;
   assign ar_fire = arvalid && arready;

   assign room = 5'(WORDS_PER_LINE) - 5'(cur_addr[5:2]);
   assign last_beat = words_left <= word_cnt_t'(room);
   assign beat_words = last_beat ? words_left : word_cnt_t'(room);

   assign beat_mask_write = ar_fire;
   assign beat_id = arid;
   always_comb begin
      for (int i = 0; i < WORDS_PER_LINE; i++) begin
         beat_mask[i] = (i >= int'(cur_addr[5:2])) &&
                        (i < int'(cur_addr[5:2]) + int'(beat_words));
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         busy <= 1'b0;
      end else if (ctx_write) begin
         busy <= 1'b1;
      end else if (ar_fire && last_beat) begin
         busy <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (ctx_write) begin
         cur_addr <= req_addr;
         words_left <= req_words;
      end else if (ar_fire) begin
         cur_addr <= cur_addr + {22'd0, beat_words, 2'b00};   // lands on a line start
         words_left <= words_left - beat_words;
      end
   end

   a_ar_hold: assert property (@(posedge clk) disable iff (!rstn)
      arvalid && !arready |=> arvalid && $stable(araddr))
      else $error("read address dropped or changed before arready");

   // a thread is returned only after all of its beats came back
   a_idle_ids: assert property (@(posedge clk) disable iff (!rstn) idle |-> arid_all_free)
      else $error("read id outstanding while idle");

endmodule

// ==== hdl/ro_task_dispatch.sv ====
`timescale 1ns/1ps

module ro_task_dispatch (
   input  logic              clk,
   input  logic              rstn,
   input  logic [31:0]       offset_base,
   input  logic [31:0]       neighbor_base,
   input  logic              in_valid,
   output logic              in_ready,
   input  ro_pkg::subtype_t  in_subtype,
   input  ro_pkg::task_t     in_task,
   input  logic [63:0]       in_data,
   input  ro_pkg::cq_slot_t  in_slot,
   output logic              req_valid,
   input  logic              req_ready,
   output logic [31:0]       req_addr,
   output ro_pkg::word_cnt_t req_words,
   output ro_pkg::task_t     req_task,
   output ro_pkg::subtype_t  req_subtype,
   output ro_pkg::cq_slot_t  req_slot,
   output logic              req_mark_last,
   output logic              child_valid,
   input  logic              child_ready,
   output ro_pkg::task_t     child_task,
   output ro_pkg::cq_slot_t  child_slot
);
   import ro_pkg::*;

   ro_data_u in_u;
   logic     is_read;
   logic     is_child;
   logic     child_room;
   logic     child_take;

   assign in_u = in_data;
   assign is_child = in_subtype == SUB_CHILD;
   assign is_read = (in_subtype == SUB_OFFSETS) ||
                    (in_subtype == SUB_EDGES && in_u.offsets.start != in_u.offsets.stop);
   assign child_room = !child_valid || child_ready;
   assign child_take = in_valid && is_child && child_room;

   // empty edge lists are consumed right away
   assign in_ready = is_child ? child_room : (is_read ? req_ready : 1'b1);
   assign req_valid = in_valid && is_read;
   assign req_task = in_task;
   assign req_slot = in_slot;

   always_comb begin
      if (in_subtype == SUB_OFFSETS) begin
         req_addr = offset_base + {in_task.locale[29:0], 2'b00};
         req_words = word_cnt_t'(ITEM_WORDS);
         req_subtype = SUB_EDGES;
         req_mark_last = 1'b0;
      end else begin
         req_addr = neighbor_base + {in_u.offsets.start[28:0], 3'b000};
         req_words = word_cnt_t'((in_u.offsets.stop - in_u.offsets.start) * ITEM_WORDS);
         req_subtype = SUB_CHILD;
         req_mark_last = 1'b1;    // last edge closes the list
      end
   end

   always_ff @(posedge clk) begin
      if (!rstn) begin
         child_valid <= 1'b0;
      end else if (child_take) begin
         child_valid <= 1'b1;
      end else if (child_ready) begin
         child_valid <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (child_take) begin
         child_task.locale <= in_u.edge_info.neighbor;
         child_task.ts <= in_task.ts + in_u.edge_info.weight;
         child_slot <= in_slot;
      end
   end

   a_child_hold: assert property (@(posedge clk) disable iff (!rstn)
      child_valid && !child_ready |=>
         child_valid && $stable(child_task) && $stable(child_slot))
      else $error("child task changed while stalled");

endmodule

// ==== hdl/ro_id_pool.sv ====
`timescale 1ns/1ps

module ro_id_pool #(
   parameter int LOG_DEPTH = 3
) (
   input  logic                 clk,
   input  logic                 rstn,
   input  logic                 push,
   input  logic [LOG_DEPTH-1:0] push_id,
   input  logic                 pop,
   output logic [LOG_DEPTH-1:0] top_id,
   output logic                 empty,
   output logic                 full
);

   localparam int DEPTH = 2 ** LOG_DEPTH;

   logic [LOG_DEPTH-1:0] ring [DEPTH];
   logic [LOG_DEPTH:0]   head;       // extra bit tells full from empty
   logic [LOG_DEPTH:0]   tail;

   assign top_id = ring[head[LOG_DEPTH-1:0]];
   assign empty = head == tail;
   assign full = (head[LOG_DEPTH-1:0] == tail[LOG_DEPTH-1:0]) &&
                 (head[LOG_DEPTH] != tail[LOG_DEPTH]);

   always_ff @(posedge clk) begin
      if (!rstn) begin
         head <= '0;
         tail <= {1'b1, {LOG_DEPTH{1'b0}}};
         for (int i = 0; i < DEPTH; i++) begin
            ring[i] <= LOG_DEPTH'(i);     // every id starts out free
         end
      end else begin
         if (pop) head <= head + 1'b1;
         if (push) begin
            ring[tail[LOG_DEPTH-1:0]] <= push_id;
            tail <= tail + 1'b1;
         end
      end
   end

   a_no_underflow: assert property (@(posedge clk) disable iff (!rstn) !(pop && empty))
      else $error("id pool popped while empty");
   a_no_overflow: assert property (@(posedge clk) disable iff (!rstn) !(push && full))
      else $error("id pool pushed while full");

endmodule

// ==== hdl/ro_pkg.sv ====
package ro_pkg;

   localparam int N_THREADS = 8;
   localparam int LOG_N_THREADS = 3;
   typedef logic [LOG_N_THREADS-1:0] thread_t;

   localparam int N_ARIDS = 32;
   localparam int LOG_N_ARIDS = 5;
   typedef logic [LOG_N_ARIDS-1:0] arid_t;

   // 64-byte memory line seen as 32-bit words
   localparam int WORDS_PER_LINE = 16;
   typedef logic [WORDS_PER_LINE*32-1:0] line_t;
   typedef logic [WORDS_PER_LINE-1:0] word_mask_t;
   typedef logic [7:0] word_cnt_t;

   typedef logic [1:0] subtype_t;
   localparam subtype_t SUB_OFFSETS = 2'd0;
   localparam subtype_t SUB_EDGES = 2'd1;
   localparam subtype_t SUB_CHILD = 2'd2;

   typedef logic [5:0] cq_slot_t;

   typedef struct packed {
      logic [31:0] ts;
      logic [31:0] locale;
   } task_t;

   typedef struct packed {
      logic [31:0] stop;      // one past the last edge
      logic [31:0] start;
   } offsets_t;

   typedef struct packed {
      logic [31:0] weight;
      logic [31:0] neighbor;
   } edge_info_t;

   // same data word, read as an offset pair or as an edge
   typedef union packed {
      offsets_t   offsets;
      edge_info_t edge_info;
   } ro_data_u;

   localparam int ITEM_WORDS = 2;

endpackage
